// File: hw/corePkg.sv
package corePkg;

    localparam int xlen = 32;
    localparam int regAddrW = 5;

    typedef logic [xlen-1:0] word_t;
    typedef logic [regAddrW-1:0] regIdx_t;

    // opOther catches every unsupported RV32I major opcode
    typedef enum logic [6:0] {
        opLui    = 7'b0110111,
        opOpImm  = 7'b0010011,
        opOp     = 7'b0110011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opBranch = 7'b1100011,
        opJal    = 7'b1101111,
        opOther  = 7'b0000000
    } opcode_t;

    typedef enum logic [1:0] {
        aluAdd,
        aluSub,
        aluPassB
    } aluOp_t;

    typedef enum logic [1:0] {
        resAlu,
        resMem,
        resPcPlus4
    } resultSrc_t;

    // everything execute and writeback need from one instruction
    typedef struct packed {
        word_t      pc;
        word_t      rs1Val;
        word_t      rs2Val;
        word_t      imm;
        regIdx_t    rd;
        aluOp_t     aluOp;
        logic       aluSrcImm;
        resultSrc_t resultSrc;
        logic       regWrite;
        logic       memRead;
        logic       memWrite;
        logic       isBranch;
        logic       branchOnEqual;
        logic       isJal;
    } decoded_t;

endpackage

// File: hw/coreIfs.sv
`timescale 1ns/1ps

// single-beat AXI4-style read address and read data channels
interface axiReadIf;
    corePkg::word_t araddr;
    logic           arvalid;
    logic           arready;
    corePkg::word_t rdata;
    logic           rvalid;
    logic           rready;

    modport manager (
        output araddr,
        output arvalid,
        input  arready,
        input  rdata,
        input  rvalid,
        output rready
    );

    modport subordinate (
        input  araddr,
        input  arvalid,
        output arready,
        output rdata,
        output rvalid,
        input  rready
    );
endinterface

// decode to execute
interface decExeIf;
    corePkg::decoded_t payload;
    logic              decValid;

    modport producer (output payload, output decValid);
    modport consumer (input payload, input decValid);
endinterface

// execute to memory access
interface exeMemIf;
    corePkg::decoded_t payload;
    corePkg::word_t    aluResult;
    logic              taken;
    corePkg::word_t    target;
    logic              exeValid;

    modport producer (
        output payload,
        output aluResult,
        output taken,
        output target,
        output exeValid
    );

    modport consumer (
        input payload,
        input aluResult,
        input taken,
        input target,
        input exeValid
    );
endinterface

// File: hw/fetchUnit.sv
`timescale 1ns/1ps

module fetchUnit #(
    parameter corePkg::word_t resetVector = 32'h0000_0000
) (
    input  logic           clock,
    input  logic           rst,
    input  logic           retire,
    input  corePkg::word_t nextPc,
    axiReadIf.manager      fetchBus,
    output logic           instValid,
    output corePkg::word_t instruction,
    output corePkg::word_t pc
);

    typedef enum logic {
        fetchIdle,
        fetchWait
    } fetchState_t;

    fetchState_t state;
    // first fetch after reset needs no retire
    logic        bootFetch;

    assign fetchBus.araddr = pc;
    assign fetchBus.rready = (state == fetchWait);

    always_ff @(posedge clock) begin
        if (rst) begin
            state            <= fetchIdle;
            bootFetch        <= 1'b1;
            fetchBus.arvalid <= 1'b0;
            instValid        <= 1'b0;
            pc               <= resetVector;
        end else begin
            instValid <= 1'b0;
            case (state)
                fetchIdle: begin
                    if (bootFetch || retire) begin
                        fetchBus.arvalid <= 1'b1;
                        bootFetch        <= 1'b0;
                        state            <= fetchWait;
                        if (retire) begin
                            pc <= nextPc;
                        end
                    end
                end
                fetchWait: begin
                    if (fetchBus.arvalid && fetchBus.arready) begin
                        fetchBus.arvalid <= 1'b0;
                    end
                    if (fetchBus.rvalid && fetchBus.rready) begin
                        instruction <= fetchBus.rdata;
                        instValid   <= 1'b1;
                        state       <= fetchIdle;
                    end
                end
                default: state <= fetchIdle;
            endcase
        end
    end

    // writeback must never overlap with the next instruction fetch
    retireWhileFetching: assert property (@(posedge clock) disable iff (rst)
        retire |-> state == fetchIdle);

endmodule

// File: hw/decodeUnit.sv
`timescale 1ns/1ps

module decodeUnit (
    input  logic            clock,
    input  logic            rst,
    input  logic            instValid,
    input  corePkg::word_t  instruction,
    input  corePkg::word_t  pc,
    input  logic            regWe,
    input  corePkg::regIdx_t regRd,
    input  corePkg::word_t  regData,
    decExeIf.producer       toExe
);

    // x0 is not stored
    corePkg::word_t    regs [1:31];
    corePkg::opcode_t  op;
    corePkg::decoded_t dec;
    corePkg::regIdx_t  rs1;
    corePkg::regIdx_t  rs2;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    corePkg::word_t    immI;
    corePkg::word_t    immS;
    corePkg::word_t    immB;
    corePkg::word_t    immU;
    corePkg::word_t    immJ;

    assign rs1    = instruction[19:15];
    assign rs2    = instruction[24:20];
    assign funct3 = instruction[14:12];
    assign funct7 = instruction[31:25];

    assign immI = {{20{instruction[31]}}, instruction[31:20]};
    assign immS = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
    assign immB = {{19{instruction[31]}}, instruction[31], instruction[7],
                   instruction[30:25], instruction[11:8], 1'b0};
    assign immU = {instruction[31:12], 12'b0};
    assign immJ = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                   instruction[20], instruction[30:21], 1'b0};

    always_comb begin
        case (instruction[6:0])
            corePkg::opLui:    op = corePkg::opLui;
            corePkg::opOpImm:  op = corePkg::opOpImm;
            corePkg::opOp:     op = corePkg::opOp;
            corePkg::opLoad:   op = corePkg::opLoad;
            corePkg::opStore:  op = corePkg::opStore;
            corePkg::opBranch: op = corePkg::opBranch;
            corePkg::opJal:    op = corePkg::opJal;
            default:           op = corePkg::opOther;
        endcase
    end

    always_comb begin
        dec        = '0;
        dec.pc     = pc;
        dec.rs1Val = (rs1 == '0) ? '0 : regs[rs1];
        dec.rs2Val = (rs2 == '0) ? '0 : regs[rs2];
        dec.rd     = instruction[11:7];
        // unsupported funct fields leave all controls low
        case (op)
            corePkg::opLui: begin
                dec.imm       = immU;
                dec.aluOp     = corePkg::aluPassB;
                dec.aluSrcImm = 1'b1;
                dec.regWrite  = 1'b1;
            end
            corePkg::opOpImm: begin
                dec.imm       = immI;
                dec.aluSrcImm = 1'b1;
                dec.regWrite  = (funct3 == 3'b000);
            end
            corePkg::opOp: begin
                dec.aluOp    = (funct7 == 7'b0100000) ? corePkg::aluSub : corePkg::aluAdd;
                dec.regWrite = (funct3 == 3'b000)
                    && (funct7 == 7'b0000000 || funct7 == 7'b0100000);
            end
            corePkg::opLoad: begin
                dec.imm       = immI;
                dec.aluSrcImm = 1'b1;
                dec.resultSrc = corePkg::resMem;
                dec.memRead   = (funct3 == 3'b010);
                dec.regWrite  = (funct3 == 3'b010);
            end
            corePkg::opStore: begin
                dec.imm       = immS;
                dec.aluSrcImm = 1'b1;
                dec.memWrite  = (funct3 == 3'b010);
            end
            corePkg::opBranch: begin
                dec.imm           = immB;
                dec.isBranch      = (funct3 == 3'b000 || funct3 == 3'b001);
                dec.branchOnEqual = (funct3 == 3'b000);
            end
            corePkg::opJal: begin
                dec.imm       = immJ;
                dec.resultSrc = corePkg::resPcPlus4;
                dec.regWrite  = 1'b1;
                dec.isJal     = 1'b1;
            end
            default: dec.imm = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (regWe && regRd != '0) begin
            regs[regRd] <= regData;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            toExe.decValid <= 1'b0;
        end else begin
            toExe.decValid <= instValid;
        end
        if (instValid) begin
            toExe.payload <= dec;
        end
    end

endmodule

// File: hw/executeUnit.sv
`timescale 1ns/1ps

module executeUnit (
    input  logic      clock,
    input  logic      rst,
    decExeIf.consumer fromDec,
    exeMemIf.producer toMem
);

    corePkg::word_t opB;
    corePkg::word_t aluOut;
    logic           takenNext;

    assign opB = fromDec.payload.aluSrcImm ? fromDec.payload.imm : fromDec.payload.rs2Val;

    always_comb begin
        case (fromDec.payload.aluOp)
            corePkg::aluSub:   aluOut = fromDec.payload.rs1Val - opB;
            corePkg::aluPassB: aluOut = opB;
            default:           aluOut = fromDec.payload.rs1Val + opB;
        endcase
    end

    // beq takes on equal, bne on not equal
    assign takenNext = fromDec.payload.isBranch
        && ((fromDec.payload.rs1Val == fromDec.payload.rs2Val)
            == fromDec.payload.branchOnEqual);

    always_ff @(posedge clock) begin
        if (rst) begin
            toMem.exeValid <= 1'b0;
        end else begin
            toMem.exeValid <= fromDec.decValid;
        end
        if (fromDec.decValid) begin
            toMem.payload   <= fromDec.payload;
            toMem.aluResult <= aluOut;
            toMem.taken     <= takenNext;
            toMem.target    <= fromDec.payload.pc + fromDec.payload.imm;
        end
    end

endmodule

// File: hw/memAccessUnit.sv
`timescale 1ns/1ps

module memAccessUnit (
    input  logic             clock,
    input  logic             rst,
    exeMemIf.consumer        fromExe,
    axiReadIf.manager        loadBus,
    output logic             awvalid,
    output corePkg::word_t   awaddr,
    input  logic             awready,
    output logic             wvalid,
    output corePkg::word_t   wdata,
    input  logic             wready,
    input  logic             bvalid,
    output logic             bready,
    output logic             retire,
    output corePkg::word_t   nextPc,
    output logic             regWe,
    output corePkg::regIdx_t regRd,
    output corePkg::word_t   regData
);

    typedef enum logic [1:0] {
        memIdle,
        memLoad,
        memStore,
        memRetire
    } memState_t;

    memState_t      state;
    corePkg::word_t loadData;
    corePkg::word_t pcPlus4;

    // execute holds its outputs until the next instruction
    assign loadBus.araddr = fromExe.aluResult;
    assign loadBus.rready = (state == memLoad);
    assign awaddr         = fromExe.aluResult;
    assign wdata          = fromExe.payload.rs2Val;
    assign bready         = (state == memStore);

    assign pcPlus4 = fromExe.payload.pc + 32'd4;
    assign retire  = (state == memRetire);
    assign regWe   = retire && fromExe.payload.regWrite;
    assign regRd   = fromExe.payload.rd;
    assign nextPc  = (fromExe.taken || fromExe.payload.isJal) ? fromExe.target : pcPlus4;

    always_comb begin
        case (fromExe.payload.resultSrc)
            corePkg::resMem:     regData = loadData;
            corePkg::resPcPlus4: regData = pcPlus4;
            default:             regData = fromExe.aluResult;
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            state           <= memIdle;
            loadBus.arvalid <= 1'b0;
            awvalid         <= 1'b0;
            wvalid          <= 1'b0;
        end else begin
            case (state)
                memIdle: begin
                    if (fromExe.exeValid) begin
                        if (fromExe.payload.memRead) begin
                            loadBus.arvalid <= 1'b1;
                            state           <= memLoad;
                        end else if (fromExe.payload.memWrite) begin
                            awvalid <= 1'b1;
                            wvalid  <= 1'b1;
                            state   <= memStore;
                        end else begin
                            state <= memRetire;
                        end
                    end
                end
                memLoad: begin
                    if (loadBus.arvalid && loadBus.arready) begin
                        loadBus.arvalid <= 1'b0;
                    end
                    if (loadBus.rvalid && loadBus.rready) begin
                        loadData <= loadBus.rdata;
                        state    <= memRetire;
                    end
                end
                memStore: begin
                    // AW and W may be accepted in either order
                    if (awready) begin
                        awvalid <= 1'b0;
                    end
                    if (wready) begin
                        wvalid <= 1'b0;
                    end
                    if (bvalid) begin
                        state <= memRetire;
                    end
                end
                default: state <= memIdle;
            endcase
        end
    end

    // write data only ever belongs to a decoded store
    wvalidOnlyForStore: assert property (@(posedge clock) disable iff (rst)
        wvalid |-> state == memStore && fromExe.payload.memWrite);

endmodule

// File: hw/readArbiter.sv
`timescale 1ns/1ps

module readArbiter (
    input  logic           clock,
    input  logic           rst,
    axiReadIf.subordinate  fetchBus,
    axiReadIf.subordinate  loadBus,
    output logic           arvalid,
    output corePkg::word_t araddr,
    input  logic           arready,
    input  logic           rvalid,
    input  corePkg::word_t rdata,
    output logic           rready
);

    // busy from address handshake to data handshake
    logic busy;
    logic ownerIsLoad;

    // load wins a tie
    assign arvalid          = !busy && (loadBus.arvalid || fetchBus.arvalid);
    assign araddr           = loadBus.arvalid ? loadBus.araddr : fetchBus.araddr;
    assign loadBus.arready  = !busy && arready;
    assign fetchBus.arready = !busy && !loadBus.arvalid && arready;

    assign loadBus.rvalid  = busy && ownerIsLoad && rvalid;
    assign fetchBus.rvalid = busy && !ownerIsLoad && rvalid;
    assign loadBus.rdata   = rdata;
    assign fetchBus.rdata  = rdata;
    assign rready          = busy && (ownerIsLoad ? loadBus.rready : fetchBus.rready);

    always_ff @(posedge clock) begin
        if (rst) begin
            busy        <= 1'b0;
            ownerIsLoad <= 1'b0;
        end else if (arvalid && arready) begin
            busy        <= 1'b1;
            ownerIsLoad <= loadBus.arvalid;
        end else if (rvalid && rready) begin
            busy <= 1'b0;
        end
    end

    // the recorded owner is the manager still waiting for its data
    ownerHeldWhileBusy: assert property (@(posedge clock) disable iff (rst)
        busy |-> (ownerIsLoad ? loadBus.rready : fetchBus.rready));

endmodule

// File: hw/fireCore.sv
`timescale 1ns/1ps

module fireCore #(
    parameter corePkg::word_t resetVector = 32'h0000_0000
) (
    input  logic           clock,
    input  logic           rst,
    output logic           arvalid,
    output corePkg::word_t araddr,
    input  logic           arready,
    input  logic           rvalid,
    input  corePkg::word_t rdata,
    output logic           rready,
    output logic           awvalid,
    output corePkg::word_t awaddr,
    input  logic           awready,
    output logic           wvalid,
    output corePkg::word_t wdata,
    input  logic           wready,
    input  logic           bvalid,
    output logic           bready
);

    axiReadIf fetchBus ();
    axiReadIf loadBus ();
    decExeIf  decExe ();
    exeMemIf  exeMem ();

    logic             instValid;
    corePkg::word_t   instruction;
    corePkg::word_t   pc;
    logic             retire;
    corePkg::word_t   nextPc;
    logic             regWe;
    corePkg::regIdx_t regRd;
    corePkg::word_t   regData;

    fetchUnit #(
        .resetVector(resetVector)
    ) fetch (
        .clock(clock),
        .rst(rst),
        .retire(retire),
        .nextPc(nextPc),
        .fetchBus(fetchBus),
        .instValid(instValid),
        .instruction(instruction),
        .pc(pc)
    );

    decodeUnit decode (
        .clock(clock),
        .rst(rst),
        .instValid(instValid),
        .instruction(instruction),
        .pc(pc),
        .regWe(regWe),
        .regRd(regRd),
        .regData(regData),
        .toExe(decExe)
    );

    executeUnit execute (
        .clock(clock),
        .rst(rst),
        .fromDec(decExe),
        .toMem(exeMem)
    );

    memAccessUnit memAccess (
        .clock(clock),
        .rst(rst),
        .fromExe(exeMem),
        .loadBus(loadBus),
        .awvalid(awvalid),
        .awaddr(awaddr),
        .awready(awready),
        .wvalid(wvalid),
        .wdata(wdata),
        .wready(wready),
        .bvalid(bvalid),
        .bready(bready),
        .retire(retire),
        .nextPc(nextPc),
        .regWe(regWe),
        .regRd(regRd),
        .regData(regData)
    );

    readArbiter arbiter (
        .clock(clock),
        .rst(rst),
        .fetchBus(fetchBus),
        .loadBus(loadBus),
        .arvalid(arvalid),
        .araddr(araddr),
        .arready(arready),
        .rvalid(rvalid),
        .rdata(rdata),
        .rready(rready)
    );

endmodule

// File: sim/fireCoreTb.sv
`timescale 1ns/1ps

module fireCoreTb;

    localparam int numInstr = 200;
    localparam int cycleLimit = numInstr * 40;
    localparam logic [31:0] resetVector = 32'h0000_0200;

    typedef enum int {
        kindLui,
        kindAddi,
        kindAdd,
        kindSub,
        kindLw,
        kindSw,
        kindBeq,
        kindBne,
        kindJal,
        kindNop
    } instKind_t;

    logic        clock = 1'b0;
    logic        rst = 1'b1;
    logic        arvalid;
    logic [31:0] araddr;
    logic        arready = 1'b0;
    logic        rvalid = 1'b0;
    logic [31:0] rdata = 32'h0;
    logic        rready;
    logic        awvalid;
    logic [31:0] awaddr;
    logic        awready = 1'b0;
    logic        wvalid;
    logic [31:0] wdata;
    logic        wready = 1'b0;
    logic        bvalid = 1'b0;
    logic        bready;

    logic [31:0] rngState = 32'h4ef80b16;

    instKind_t   progKind [numInstr];
    logic [4:0]  progRd [numInstr];
    logic [4:0]  progRs1 [numInstr];
    logic [4:0]  progRs2 [numInstr];
    logic [31:0] progImm [numInstr];

    // bus side memory and the model's separate data copy
    logic [31:0] memory [logic [31:0]];
    logic [31:0] modelMem [logic [31:0]];
    logic [31:0] readQ [$];
    logic [31:0] storeAddrQ [$];
    logic [31:0] storeDataQ [$];

    // responder state
    int          arWait = 0;
    int          rWait = 0;
    int          awWait = 0;
    int          wWait = 0;
    int          bWait = 0;
    logic        rPending = 1'b0;
    logic [31:0] rAddr = 32'h0;
    logic        awDone = 1'b0;
    logic        wDone = 1'b0;
    logic [31:0] awAddrSeen = 32'h0;
    logic [31:0] wDataSeen = 32'h0;
    logic        arHeld = 1'b0;
    logic        awHeld = 1'b0;
    logic        wHeld = 1'b0;
    logic [31:0] arAddrHeld = 32'h0;
    logic [31:0] awAddrHeld = 32'h0;
    logic [31:0] wDataHeld = 32'h0;
    logic        sawFirstRead = 1'b0;
    int          cycleCount = 0;

    fireCore #(
        .resetVector(resetVector)
    ) dut_i (
        .clock(clock),
        .rst(rst),
        .arvalid(arvalid),
        .araddr(araddr),
        .arready(arready),
        .rvalid(rvalid),
        .rdata(rdata),
        .rready(rready),
        .awvalid(awvalid),
        .awaddr(awaddr),
        .awready(awready),
        .wvalid(wvalid),
        .wdata(wdata),
        .wready(wready),
        .bvalid(bvalid),
        .bready(bready)
    );

    initial begin
        forever #4 clock = ~clock;
    end

    function automatic logic [31:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic int pickDelay();
        return int'(nextRandom() % 32'd4);
    endfunction

    // untouched words differ at every address
    function automatic logic [31:0] fillWord(logic [31:0] addr);
        return {addr[15:0], addr[31:16]} ^ 32'h9e37_79b9;
    endfunction

    function automatic logic [31:0] readWord(logic [31:0] addr);
        return memory.exists(addr) ? memory[addr] : fillWord(addr);
    endfunction

    function automatic logic [31:0] encode(instKind_t kind, logic [4:0] rd, logic [4:0] rs1,
                                           logic [4:0] rs2, logic [31:0] imm);
        case (kind)
            kindLui:  return {imm[31:12], rd, 7'b0110111};
            kindAddi: return {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
            kindAdd:  return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
            kindSub:  return {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
            kindLw:   return {imm[11:0], rs1, 3'b010, rd, 7'b0000011};
            kindSw:   return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
            kindBeq:  return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
            kindBne:  return {imm[12], imm[10:5], rs2, rs1, 3'b001, imm[4:1], imm[11], 7'b1100011};
            kindJal:  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
            default:  return 32'h0000_0000;
        endcase
    endfunction

    task automatic stopWithFail();
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic checkEqual(logic [31:0] actual, logic [31:0] expected, string what);
        if (actual !== expected) begin
            $display("[FAIL] %0t: %s: got %h, expected %h", $time, what, actual, expected);
            stopWithFail();
        end
    endtask

    // x31 holds the data base and x1..x7 are seeded first
    task automatic buildProgram();
        logic [31:0] r;
        int          span;
        int          hop;
        for (int i = 0; i < numInstr; i++) begin
            r = nextRandom();
            progRd[i]  = {2'b00, r[2:0]};
            progRs1[i] = {2'b00, r[5:3]};
            progRs2[i] = {2'b00, r[8:6]};
            progImm[i] = {{20{r[31]}}, r[31:20]};
            span = numInstr - 1 - i;
            hop = 1 + int'(nextRandom() % 32'((span < 4) ? span : 4));
            if (i == 0) begin
                progKind[i] = kindLui;
                progRd[i]   = 5'd31;
                progImm[i]  = 32'h0000_1000;
            end else if (i < 8) begin
                progKind[i] = kindAddi;
                progRd[i]   = 5'(i);
                progRs1[i]  = 5'd0;
            end else if (i % 4 == 3) begin
                progKind[i] = kindSw;
                progRs1[i]  = 5'd31;
                progImm[i]  = {26'b0, r[23:20], 2'b00};
            end else begin
                case (int'(nextRandom() % 32'd10))
                    0: begin
                        progKind[i] = kindLui;
                        progImm[i]  = {r[31:12], 12'b0};
                    end
                    2: progKind[i] = kindAdd;
                    3: progKind[i] = kindSub;
                    4: begin
                        progKind[i] = kindLw;
                        progRs1[i]  = 5'd31;
                        progImm[i]  = {26'b0, r[23:20], 2'b00};
                    end
                    5: progKind[i] = kindBeq;
                    6: progKind[i] = kindBne;
                    7: progKind[i] = kindJal;
                    8: progKind[i] = kindNop;
                    default: progKind[i] = kindAddi;
                endcase
                if (progKind[i] inside {kindBeq, kindBne, kindJal}) begin
                    progImm[i] = 32'(hop * 4);
                end
            end
            memory[resetVector + 32'(4 * i)] =
                encode(progKind[i], progRd[i], progRs1[i], progRs2[i], progImm[i]);
        end
    endtask

    // instruction level model yielding the expected reads and stores in order
    task automatic runModel();
        logic [31:0] x [32];
        logic [31:0] pc;
        logic [31:0] nextPc;
        logic [31:0] addr;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] imm;
        int          idx;
        for (int r = 0; r < 32; r++) begin
            x[r] = 32'h0;
        end
        pc = resetVector;
        idx = 0;
        while (idx < numInstr) begin
            rd = progRd[idx];
            rs1 = progRs1[idx];
            rs2 = progRs2[idx];
            imm = progImm[idx];
            readQ.push_back(pc);
            nextPc = pc + 32'd4;
            case (progKind[idx])
                kindLui:  x[rd] = imm;
                kindAddi: x[rd] = x[rs1] + imm;
                kindAdd:  x[rd] = x[rs1] + x[rs2];
                kindSub:  x[rd] = x[rs1] - x[rs2];
                kindLw: begin
                    addr = x[rs1] + imm;
                    readQ.push_back(addr);
                    x[rd] = modelMem.exists(addr) ? modelMem[addr] : fillWord(addr);
                end
                kindSw: begin
                    addr = x[rs1] + imm;
                    storeAddrQ.push_back(addr);
                    storeDataQ.push_back(x[rs2]);
                    modelMem[addr] = x[rs2];
                end
                kindBeq: nextPc = (x[rs1] == x[rs2]) ? pc + imm : nextPc;
                kindBne: nextPc = (x[rs1] != x[rs2]) ? pc + imm : nextPc;
                kindJal: begin
                    x[rd] = pc + 32'd4;
                    nextPc = pc + imm;
                end
                default: x[0] = 32'h0;
            endcase
            x[0] = 32'h0;
            pc = nextPc;
            idx = int'((pc - resetVector) >> 2);
        end
    endtask

    // AXI memory deciding each handshake for the next rising edge
    always @(negedge clock) begin
        if (!rst) begin
            if (arHeld) begin
                checkEqual(32'(arvalid), 32'd1, "arvalid dropped before handshake");
                checkEqual(araddr, arAddrHeld, "araddr changed while waiting");
            end
            if (awHeld) begin
                checkEqual(32'(awvalid), 32'd1, "awvalid dropped before handshake");
                checkEqual(awaddr, awAddrHeld, "awaddr changed while waiting");
            end
            if (wHeld) begin
                checkEqual(32'(wvalid), 32'd1, "wvalid dropped before handshake");
                checkEqual(wdata, wDataHeld, "wdata changed while waiting");
            end
            if (!sawFirstRead) begin
                checkEqual(32'(awvalid), 32'd0, "awvalid before first fetch");
                checkEqual(32'(wvalid), 32'd0, "wvalid before first fetch");
                if (arvalid) begin
                    checkEqual(araddr, resetVector, "first fetch address");
                    sawFirstRead = 1'b1;
                end
            end
            if (!rPending) begin
                checkEqual(32'(rready), 32'd0, "rready with no read outstanding");
            end

            // read data
            rvalid = 1'b0;
            if (rPending) begin
                if (rWait != 0) begin
                    rWait--;
                end else begin
                    rvalid = 1'b1;
                    rdata = readWord(rAddr);
                    rPending = !rready;
                end
            end

            // extra fetches past the program are left waiting
            arready = 1'b0;
            arHeld = arvalid;
            arAddrHeld = araddr;
            if (arvalid && !rPending && readQ.size() != 0) begin
                if (arWait != 0) begin
                    arWait--;
                end else begin
                    checkEqual(araddr, readQ.pop_front(), "read address");
                    arready = 1'b1;
                    arHeld = 1'b0;
                    rPending = 1'b1;
                    rAddr = araddr;
                    rWait = pickDelay();
                    arWait = pickDelay();
                end
            end

            // write response once both AW and W went through
            bvalid = 1'b0;
            if (awDone && wDone) begin
                if (bWait != 0) begin
                    bWait--;
                end else if (storeAddrQ.size() == 0) begin
                    $display("store to %h issued after the program ended", awAddrSeen);
                    stopWithFail();
                end else begin
                    checkEqual(awAddrSeen, storeAddrQ.pop_front(), "store address");
                    checkEqual(wDataSeen, storeDataQ.pop_front(), "store data");
                    checkEqual(32'(bready), 32'd1, "bready during write response");
                    memory[awAddrSeen] = wDataSeen;
                    bvalid = 1'b1;
                    awDone = 1'b0;
                    wDone = 1'b0;
                    bWait = pickDelay();
                end
            end

            awready = 1'b0;
            awHeld = awvalid && !awDone;
            awAddrHeld = awaddr;
            if (awvalid && !awDone && awWait == 0) begin
                awready = 1'b1;
                awHeld = 1'b0;
                awDone = 1'b1;
                awAddrSeen = awaddr;
                awWait = pickDelay();
            end else if (awvalid && !awDone) begin
                awWait--;
            end

            wready = 1'b0;
            wHeld = wvalid && !wDone;
            wDataHeld = wdata;
            if (wvalid && !wDone && wWait == 0) begin
                wready = 1'b1;
                wHeld = 1'b0;
                wDone = 1'b1;
                wDataSeen = wdata;
                wWait = pickDelay();
            end else if (wvalid && !wDone) begin
                wWait--;
            end
        end
    end

    initial begin
        buildProgram();
        runModel();
        repeat (3) begin
            @(negedge clock);
            checkEqual(32'(arvalid), 32'd0, "arvalid during reset");
            checkEqual(32'(awvalid), 32'd0, "awvalid during reset");
            checkEqual(32'(wvalid), 32'd0, "wvalid during reset");
            checkEqual(32'(rready), 32'd0, "rready during reset");
            checkEqual(32'(bready), 32'd0, "bready during reset");
        end
        rst = 1'b0;
        while (readQ.size() != 0 || storeAddrQ.size() != 0) begin
            @(negedge clock);
            cycleCount++;
            if (cycleCount > cycleLimit) begin
                $display("timeout after %0d cycles, %0d reads and %0d stores never arrived",
                         cycleCount, readQ.size(), storeAddrQ.size());
                stopWithFail();
            end
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// File: sources.f
hw/corePkg.sv
hw/coreIfs.sv
hw/fetchUnit.sv
hw/decodeUnit.sv
hw/executeUnit.sv
hw/memAccessUnit.sv
hw/readArbiter.sv
hw/fireCore.sv
sim/fireCoreTb.sv

// File: Makefile
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f sources.f --top-module fireCoreTb -o VfireCoreTb

run: build
	@out="$$(./obj_dir/VfireCoreTb)"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

lint:
	verilator --lint-only -Wall --timing -f sources.f --top-module fireCore

clean:
	rm -rf obj_dir
